// File: logic/lsu_pkg.sv
// Load unit package with bus geometry, pending limit and the bus word views
`default_nettype none

package lsu_pkg;

  // Byte address width of the request and memory ports
  localparam int ADDR_W = 32;

  // Returned word geometry
  localparam int WORD_BYTES = 4;
  localparam int WORD_W = 8 * WORD_BYTES;

  // Memory bus word geometry
  localparam int BUS_BYTES = 32;
  localparam int BUS_W = 8 * BUS_BYTES;

  // Address bits below a bus word and below a word
  localparam int BYTE_SEL_W = $clog2(BUS_BYTES);
  localparam int ALIGN_W = $clog2(WORD_BYTES);

  // Word position inside the bus word
  localparam int SEG_W = BYTE_SEL_W - ALIGN_W;
  localparam int NUM_SEGS = 2 ** SEG_W;

  // Reads accepted but not yet taken downstream and the depth of both queues
  localparam int MAX_PENDING = 8;
  // Counter holds 0 up to MAX_PENDING inclusive
  localparam int PEND_W = $clog2(MAX_PENDING + 1);
  // Queue pointer width that wraps naturally for a power-of-two depth
  localparam int PTR_W = $clog2(MAX_PENDING);

  // Bus word seen flat at the memory port or as an array of words by segment
  typedef union packed {
    logic [BUS_W-1:0] flat;
    logic [NUM_SEGS-1:0][WORD_W-1:0] seg;
  } bus_word_u;

endpackage

`default_nettype wire

// File: logic/lsu_flow_if.sv
// Stage link carrying accepted requests, steered words and downstream pops
`timescale 1ns/1ps
`default_nettype none

interface lsu_flow_if;
  import lsu_pkg::*;

  // Request taken by the memory bus this cycle
  logic accept;
  // Word position of the accepted request inside its bus word
  logic [SEG_W-1:0] seg;

  // Steered word returning from memory
  logic word_valid;
  logic [WORD_W-1:0] word;

  // Head word taken by the downstream consumer
  logic pop;

  modport issue (
    output accept,
    output seg,
    input pop
  );

  modport steer (
    input accept,
    input seg,
    output word_valid,
    output word
  );

  modport drain (
    input word_valid,
    input word,
    output pop
  );

endinterface

`default_nettype wire

// File: logic/lsu_read_issue.sv
// Read issue stage forwarding requests to memory and limiting reads in flight
`timescale 1ns/1ps
`default_nettype none

module lsu_read_issue (
  input wire logic clk,
  input wire logic reset,
  input wire logic i_valid,
  input wire logic [lsu_pkg::ADDR_W-1:0] i_address,
  input wire logic i_avm_waitrequest,
  output logic o_stall,
  output logic o_avm_read,
  output logic [lsu_pkg::ADDR_W-1:0] o_avm_address,
  output logic o_active,
  lsu_flow_if.issue flow
);
  import lsu_pkg::*;

  // Reads accepted but not yet popped downstream
  logic [PEND_W-1:0] pend_cnt;
  // Room for one more read in the return FIFO
  logic ready;

  // Full once every return slot is promised to a read
  assign ready = (pend_cnt != PEND_W'(MAX_PENDING));

  // Stall on a full pending count or a busy memory bus
  assign o_stall = !ready || i_avm_waitrequest;

  // Request goes straight through in the same cycle
  assign o_avm_read = i_valid && ready;

  // Address aligned down to the bus word
  assign o_avm_address = {i_address[ADDR_W-1:BYTE_SEL_W], {BYTE_SEL_W{1'b0}}};

  // Transfer happens only when memory does not hold the bus
  assign flow.accept = o_avm_read && !i_avm_waitrequest;

  // Word select bits ride along to the segment queue
  assign flow.seg = i_address[ALIGN_W +: SEG_W];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pend_cnt <= '0;
      o_active <= 1'b0;
    end
    else
    begin
      // Activity lags the count by one cycle
      o_active <= (pend_cnt != '0);
      // Accept and pop in the same cycle cancel out
      case ({flow.accept, flow.pop})
        2'b10: pend_cnt <= pend_cnt + 1'b1;
        2'b01: pend_cnt <= pend_cnt - 1'b1;
        default: pend_cnt <= pend_cnt;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/lsu_segment_queue.sv
// Segment index queue that steers the addressed word out of each bus word
`timescale 1ns/1ps
`default_nettype none

module lsu_segment_queue (
  input wire logic clk,
  input wire logic reset,
  input wire logic i_avm_readdatavalid,
  input wire lsu_pkg::bus_word_u i_avm_readdata,
  lsu_flow_if.steer flow
);
  import lsu_pkg::*;

  // One segment index per read still waiting for its data
  logic [SEG_W-1:0] seg_mem [MAX_PENDING];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // Index of the oldest outstanding read
  logic [SEG_W-1:0] head_seg;

  // Responses come back in order, so the head always matches
  assign head_seg = seg_mem[rd_ptr];

  // Storage written on every accepted request
  always_ff @(posedge clk)
  begin
    if (flow.accept)
    begin
      seg_mem[wr_ptr] <= flow.seg;
    end
  end

  // Pointer update
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (flow.accept)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // Pop as the matching response arrives
      if (i_avm_readdatavalid)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Steered word is ready in the response cycle
  assign flow.word_valid = i_avm_readdatavalid;
  assign flow.word = i_avm_readdata.seg[head_seg];

endmodule

`default_nettype wire

// File: logic/lsu_return_fifo.sv
// Return FIFO holding steered words in order until downstream takes them
`timescale 1ns/1ps
`default_nettype none

module lsu_return_fifo (
  input wire logic clk,
  input wire logic reset,
  input wire logic i_stall,
  output logic o_valid,
  output logic [lsu_pkg::WORD_W-1:0] o_readdata,
  lsu_flow_if.drain flow
);
  import lsu_pkg::*;

  // Word storage as deep as the pending limit
  logic [WORD_W-1:0] data_mem [MAX_PENDING];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // Words held, 0 up to MAX_PENDING
  logic [PEND_W-1:0] occ_cnt;

  // Head is visible once the count has moved past zero
  assign o_valid = (occ_cnt != '0);
  assign o_readdata = data_mem[rd_ptr];

  // Head leaves when downstream is not stalling
  assign flow.pop = o_valid && !i_stall;

  always_ff @(posedge clk)
  begin
    if (flow.word_valid)
    begin
      data_mem[wr_ptr] <= flow.word;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ_cnt <= '0;
    end
    else
    begin
      if (flow.word_valid)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (flow.pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Occupancy moves only on a lone push or a lone pop
      case ({flow.word_valid, flow.pop})
        2'b10: occ_cnt <= occ_cnt + 1'b1;
        2'b01: occ_cnt <= occ_cnt - 1'b1;
        default: occ_cnt <= occ_cnt;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/lsu_pipelined_read.sv
// Pipelined read unit joining issue, segment steering and return buffering
`timescale 1ns/1ps
`default_nettype none

module lsu_pipelined_read (
  input wire logic clk,
  input wire logic reset,
  // Upstream request side
  input wire logic i_valid,
  input wire logic [lsu_pkg::ADDR_W-1:0] i_address,
  output logic o_stall,
  // Downstream result side
  output logic o_valid,
  output logic [lsu_pkg::WORD_W-1:0] o_readdata,
  input wire logic i_stall,
  // Status
  output logic o_active,
  // Avalon memory master
  output logic [lsu_pkg::ADDR_W-1:0] o_avm_address,
  output logic o_avm_read,
  input wire logic i_avm_waitrequest,
  input wire logic [lsu_pkg::BUS_W-1:0] i_avm_readdata,
  input wire logic i_avm_readdatavalid
);
  import lsu_pkg::*;

  // Returned bus word in its union form
  bus_word_u avm_word;

  lsu_flow_if flow0 ();

  assign avm_word.flat = i_avm_readdata;

  lsu_read_issue issue0 (
    .clk(clk),
    .reset(reset),
    .i_valid(i_valid),
    .i_address(i_address),
    .i_avm_waitrequest(i_avm_waitrequest),
    .o_stall(o_stall),
    .o_avm_read(o_avm_read),
    .o_avm_address(o_avm_address),
    .o_active(o_active),
    .flow(flow0.issue)
  );

  lsu_segment_queue steer0 (
    .clk(clk),
    .reset(reset),
    .i_avm_readdatavalid(i_avm_readdatavalid),
    .i_avm_readdata(avm_word),
    .flow(flow0.steer)
  );

  lsu_return_fifo drain0 (
    .clk(clk),
    .reset(reset),
    .i_stall(i_stall),
    .o_valid(o_valid),
    .o_readdata(o_readdata),
    .flow(flow0.drain)
  );

endmodule

`default_nettype wire

// File: bench/avalon_mem_model.sv
// Avalon memory responder that answers reads in order after a chosen latency
`timescale 1ns/1ps
`default_nettype none

module avalon_mem_model (
  input wire logic clk,
  input wire logic reset,
  input wire logic i_read,
  input wire logic [lsu_pkg::ADDR_W-1:0] i_address,
  input wire logic i_waitrequest,
  input wire logic [2:0] i_latency,
  output logic [lsu_pkg::BUS_W-1:0] o_readdata,
  output logic o_readdatavalid
);
  import lsu_pkg::*;

  // Every word reads as its own byte address XOR this key
  localparam logic [31:0] DATA_KEY = 32'h5A5A_0000;

  // Reads taken from the bus and the cycle each one is due
  logic [ADDR_W-1:0] addr_q [$];
  longint due_q [$];
  longint cycle;
  longint last_due;
  logic rsp_valid = 1'b0;
  logic [BUS_W-1:0] rsp_data = '0;

  assign o_readdatavalid = rsp_valid;
  assign o_readdata = rsp_data;

  always @(posedge clk or posedge reset)
  begin
    longint due;
    if (reset)
    begin
      addr_q.delete();
      due_q.delete();
      cycle = 0;
      last_due = 0;
    end
    else
    begin
      cycle = cycle + 1;
      if (i_read && !i_waitrequest)
      begin
        due = cycle + longint'(i_latency);
        // Never overtake an older read
        if (due <= last_due)
          due = last_due + 1;
        addr_q.push_back(i_address);
        due_q.push_back(due);
        last_due = due;
      end
    end
  end

  // At most one response per cycle, changed on the falling edge
  always @(negedge clk)
  begin
    logic [ADDR_W-1:0] base;
    logic [BUS_W-1:0] word;
    rsp_valid <= 1'b0;
    if (!reset && due_q.size() != 0 && due_q[0] <= cycle)
    begin
      base = addr_q.pop_front();
      void'(due_q.pop_front());
      for (int k = 0; k < NUM_SEGS; k++)
        word[k*WORD_W +: WORD_W] = (base + 32'(4 * k)) ^ DATA_KEY;
      rsp_data <= word;
      rsp_valid <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_lsu_read.sv
// Testbench for the pipelined load unit with random memory latency and stalls
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_read;
  import lsu_pkg::*;

  localparam int DATA_READS = 300;
  localparam int ACTIVITY_READS = 20;
  // Pending phase takes a full set plus one after the release
  localparam int TOTAL_REQS = DATA_READS + MAX_PENDING + 1 + ACTIVITY_READS;
  localparam int WATCHDOG_CYCLES = TOTAL_REQS * 20 + 200;
  // Longest wait for outstanding reads once the inputs go idle
  localparam int DRAIN_CYCLES = 100;
  localparam logic [31:0] DATA_KEY = 32'h5A5A_0000;

  logic clk;
  logic reset;
  logic req_valid;
  logic [ADDR_W-1:0] req_address;
  logic req_stall;
  logic rsp_valid;
  logic [WORD_W-1:0] rsp_data;
  logic rsp_stall;
  logic active;
  logic [ADDR_W-1:0] avm_address;
  logic avm_read;
  logic avm_waitrequest;
  logic [BUS_W-1:0] avm_readdata;
  logic avm_readdatavalid;
  logic [2:0] mem_latency;

  // Scoreboard of accepted addresses, oldest first
  logic [ADDR_W-1:0] addr_q [$];
  logic [15:0] lfsr;
  int accepted;
  int taken;
  int errs [5];
  int ok_tests;
  int total;
  int seen;
  logic monitor_on;
  logic hold_full;
  // Activity expected from the previous cycle's pending count
  logic exp_active;

  lsu_pipelined_read dut0 (
    .clk(clk),
    .reset(reset),
    .i_valid(req_valid),
    .i_address(req_address),
    .o_stall(req_stall),
    .o_valid(rsp_valid),
    .o_readdata(rsp_data),
    .i_stall(rsp_stall),
    .o_active(active),
    .o_avm_address(avm_address),
    .o_avm_read(avm_read),
    .i_avm_waitrequest(avm_waitrequest),
    .i_avm_readdata(avm_readdata),
    .i_avm_readdatavalid(avm_readdatavalid)
  );

  avalon_mem_model mem0 (
    .clk(clk),
    .reset(reset),
    .i_read(avm_read),
    .i_address(avm_address),
    .i_waitrequest(avm_waitrequest),
    .i_latency(mem_latency),
    .o_readdata(avm_readdata),
    .o_readdatavalid(avm_readdatavalid)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // Word address XOR the memory model key
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ DATA_KEY;
  endfunction

  task automatic log_mismatch(input int test, input string name,
                              input logic [31:0] exp, input logic [31:0] got);
    $display("ERROR at %0d ns: %s expected %h, got %h", $time, name, exp, got);
    errs[test]++;
  endtask

  task automatic drive_idle();
    req_valid = 1'b0;
    req_address = '0;
    rsp_stall = 1'b0;
    avm_waitrequest = 1'b0;
    mem_latency = 3'd1;
  endtask

  // Valid on 3 of 4 cycles and stalls on 1 of 4
  task automatic drive_random();
    logic [31:0] r;
    take_bits(2, r);
    req_valid = (r[1:0] != 2'b00);
    take_bits(32, r);
    req_address = r;
    take_bits(2, r);
    rsp_stall = (r[1:0] == 2'b00);
    take_bits(2, r);
    avm_waitrequest = (r[1:0] == 2'b00);
    take_bits(3, r);
    mem_latency = 3'(32'd1 + r % 32'd6);
  endtask

  // Steady requests with a free memory bus
  task automatic drive_held(input logic stall);
    logic [31:0] r;
    take_bits(32, r);
    req_address = r;
    take_bits(3, r);
    mem_latency = 3'(32'd1 + r % 32'd6);
    req_valid = 1'b1;
    avm_waitrequest = 1'b0;
    rsp_stall = stall;
  endtask

  task automatic check_idle();
    assert (!req_stall) else log_mismatch(0, "o_stall", 32'd0, 32'(req_stall));
    assert (!rsp_valid) else log_mismatch(0, "o_valid", 32'd0, 32'(rsp_valid));
    assert (!avm_read) else log_mismatch(0, "o_avm_read", 32'd0, 32'(avm_read));
    assert (!active) else log_mismatch(0, "o_active", 32'd0, 32'(active));
  endtask

  task automatic report(input string name, input int n);
    if (n == 0)
    begin
      ok_tests++;
      $display("test %s: ok", name);
    end
    else
      $display("test %s: %0d errors", name, n);
  endtask

  // Waits with idle inputs until every accepted read was taken downstream
  task automatic drain_reads(input int test);
    int waited;
    waited = 0;
    while (taken != accepted && waited < DRAIN_CYCLES)
    begin
      @(negedge clk);
      waited++;
    end
    assert (taken == accepted)
    else
    begin
      $display("%0d reads still outstanding after %0d idle cycles",
               accepted - taken, DRAIN_CYCLES);
      errs[test]++;
    end
  endtask

  // Runs just before the rising edge and counts the transfers of that edge
  task automatic sample_cycle();
    int pend_now;
    logic [31:0] exp;
    pend_now = accepted - taken;
    assert (pend_now <= MAX_PENDING)
    else log_mismatch(3, "pending reads", MAX_PENDING, pend_now);
    assert (active == exp_active)
    else log_mismatch(4, "o_active", 32'(exp_active), 32'(active));
    exp_active = (pend_now != 0);
    if (avm_read)
    begin
      assert (avm_address == (req_address & 32'hFFFF_FFE0))
      else log_mismatch(1, "o_avm_address", req_address & 32'hFFFF_FFE0, avm_address);
    end
    if (hold_full)
    begin
      assert (req_stall) else log_mismatch(3, "o_stall", 32'd1, 32'(req_stall));
    end
    if (req_valid && !req_stall)
    begin
      addr_q.push_back(req_address);
      accepted++;
    end
    if (rsp_valid && !rsp_stall)
    begin
      taken++;
      assert (addr_q.size() != 0)
      else
      begin
        $display("Downstream transfer at %0d ns with no read outstanding", $time);
        errs[2]++;
      end
      if (addr_q.size() != 0)
      begin
        exp = expected_word(addr_q.pop_front());
        assert (rsp_data == exp) else log_mismatch(2, "o_readdata", exp, rsp_data);
      end
    end
  endtask

  initial
  begin
    forever
    begin
      @(negedge clk);
      #25;
      if (monitor_on)
        sample_cycle();
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, %0d of %0d reads taken",
             WATCHDOG_CYCLES, taken, accepted);
    $display("tests failed");
    $finish;
  end

  initial
  begin
    lfsr = 16'd48891;
    reset = 1'b1;
    monitor_on = 1'b0;
    hold_full = 1'b0;
    exp_active = 1'b0;
    drive_idle();
    // Three rising edges in reset, then one idle cycle after release
    for (int i = 0; i < 4; i++)
    begin
      @(negedge clk);
      if (i == 2)
      begin
        reset = 1'b0;
        monitor_on = 1'b1;
      end
      #25;
      check_idle();
    end
    report("reset_state", errs[0]);

    // Random traffic, then drain everything
    @(negedge clk);
    while (accepted < DATA_READS)
    begin
      drive_random();
      @(negedge clk);
    end
    drive_idle();
    drain_reads(2);
    report("data_order", errs[2]);

    // Fill every slot with downstream stalled
    while (accepted - taken < MAX_PENDING)
    begin
      drive_held(1'b1);
      @(negedge clk);
    end
    hold_full = 1'b1;
    repeat (12)
    begin
      drive_held(1'b1);
      @(negedge clk);
    end
    // One pop frees one slot a cycle later
    seen = accepted;
    hold_full = 1'b0;
    drive_held(1'b0);
    @(negedge clk);
    drive_held(1'b1);
    @(negedge clk);
    hold_full = 1'b1;
    repeat (6)
    begin
      drive_held(1'b1);
      @(negedge clk);
    end
    assert (accepted == seen + 1)
    else
    begin
      $display("One downstream release let %0d new reads in", accepted - seen);
      errs[3]++;
    end
    hold_full = 1'b0;
    drive_idle();
    drain_reads(3);
    report("pending_limit", errs[3]);

    // Short run, then watch the flag fall after the last transfer
    seen = accepted;
    while (accepted < seen + ACTIVITY_READS)
    begin
      drive_random();
      @(negedge clk);
    end
    drive_idle();
    drain_reads(4);
    #25;
    assert (active) else log_mismatch(4, "o_active", 32'd1, 32'(active));
    @(negedge clk);
    #25;
    assert (!active) else log_mismatch(4, "o_active", 32'd0, 32'(active));
    report("activity", errs[4]);
    report("alignment", errs[1]);

    total = 0;
    foreach (errs[t])
      total += errs[t];
    $display("%0d of 5 tests ok, %0d errors", ok_tests, total);
    if (total == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
logic/lsu_pkg.sv
logic/lsu_flow_if.sv
logic/lsu_read_issue.sv
logic/lsu_segment_queue.sv
logic/lsu_return_fifo.sv
logic/lsu_pipelined_read.sv
bench/avalon_mem_model.sv
bench/tb_lsu_read.sv

// File: Makefile
TOP := tb_lsu_read

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f build.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
